//--- sim.f
source/his_pkg.sv
source/hit_sequencer.sv
source/bin_accumulator.sv
source/hist_readout.sv
source/his_builder_top.sv
tests/his_builder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the histogram builder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module his_builder_tb -f sim.f -o his_sim \
    && ./obj_dir/his_sim | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/his_builder_tb.sv
module his_builder_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // longest wait for any single readout word, in cycles
    localparam int TIMEOUT = 400;
    localparam int WORDS = his_pkg::NUM_PIXELS * his_pkg::NUM_BINS;
    localparam int ACQ_HITS = his_pkg::HITS_PER_PIXEL * his_pkg::NUM_PIXELS;

    logic                       clk;
    logic                       res;
    logic                       hit_valid;
    logic [his_pkg::BIN_W-1:0]   hit_bin;
    logic                       frame_done;
    logic                       fill_bank;
    logic                       out_valid;
    logic                       out_bank;
    logic [his_pkg::PIX_W-1:0]   out_pixel;
    logic [his_pkg::BIN_W-1:0]   out_bin;
    logic [his_pkg::COUNT_W-1:0] out_count;

    // expected histograms per bank, plus hit position in the frame
    int exp_hist [2][his_pkg::NUM_PIXELS][his_pkg::NUM_BINS];
    int hit_idx;
    int model_bank;
    int frame_cnt = 0;
    int checks;
    int errors;
    logic [15:0] lfsr;

    his_builder_top his_builder_top_inst (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .frame_done (frame_done),
        .fill_bank  (fill_bank),
        .out_valid  (out_valid),
        .out_bank   (out_bank),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count)
    );

    always #4 clk = ~clk;

    // frame_done pulses, sampled mid-cycle
    always @(negedge clk) begin
        if (res && frame_done) begin
            frame_cnt++;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic int take_bits(input int n);
        int value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic clear_model();
        for (int b = 0; b < 2; b++) begin
            for (int p = 0; p < his_pkg::NUM_PIXELS; p++) begin
                for (int n = 0; n < his_pkg::NUM_BINS; n++) begin
                    exp_hist[b][p][n] = 0;
                end
            end
        end
        hit_idx = 0;
        model_bank = 0;
    endtask

    // one strobe, held only until the next edge unless another hit follows
    task automatic send_hit(input logic [his_pkg::BIN_W-1:0] bin);
        int pixel;
        pixel = (hit_idx / his_pkg::HITS_PER_PIXEL) % his_pkg::NUM_PIXELS;
        @(posedge clk);
        hit_valid <= 1'b1;
        hit_bin <= bin;
        exp_hist[model_bank][pixel][bin]++;
        hit_idx++;
        // frame complete, model swaps banks like the DUT
        if (hit_idx == his_pkg::HITS_PER_FRAME) begin
            hit_idx = 0;
            model_bank = 1 - model_bank;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            hit_valid <= 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        res <= 1'b0;
        repeat (3) @(posedge clk);
        res <= 1'b1;
    endtask

    // pixel 0 of every acquisition gets a run of one bin
    task automatic send_random_frame();
        logic [his_pkg::BIN_W-1:0] run_bin;
        logic [his_pkg::BIN_W-1:0] bin;
        run_bin = '0;
        for (int k = 0; k < his_pkg::HITS_PER_FRAME; k++) begin
            if (k % ACQ_HITS == 0) begin
                run_bin = his_pkg::BIN_W'(take_bits(his_pkg::BIN_W));
            end
            if (k % ACQ_HITS < his_pkg::HITS_PER_PIXEL) begin
                bin = run_bin;
            end else begin
                bin = his_pkg::BIN_W'(take_bits(his_pkg::BIN_W));
            end
            send_hit(bin);
        end
    endtask

    // one full dump, pixel major, bins ascending, no gaps
    task automatic collect_dump(input int bank);
        int waited;
        int p;
        int n;
        for (int w = 0; w < WORDS; w++) begin
            p = w / his_pkg::NUM_BINS;
            n = w % his_pkg::NUM_BINS;
            waited = 0;
            @(negedge clk);
            while (!out_valid && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!out_valid) begin
                $display("timeout waiting for word %0d of the bank %0d dump", w, bank);
                errors++;
                return;
            end
            if (w > 0 && waited > 0) begin
                $display("readout word %0d of bank %0d came late, stream had a gap", w, bank);
                errors++;
            end
            check_value("out_bank", bank, int'(out_bank));
            check_value("out_pixel", p, int'(out_pixel));
            check_value("out_bin", n, int'(out_bin));
            check_value("out_count", exp_hist[bank][p][n], int'(out_count));
            // entry is cleared as it is read
            exp_hist[bank][p][n] = 0;
        end
        @(negedge clk);
        check_value("out_valid after last word", 0, int'(out_valid));
    endtask

    task automatic idle_after_reset();
        repeat (10) begin
            @(negedge clk);
            check_value("out_valid", 0, int'(out_valid));
            check_value("frame_done", 0, int'(frame_done));
            check_value("fill_bank", 0, int'(fill_bank));
        end
    endtask

    // bin equals pixel, so 9 lands on the diagonal
    task automatic fixed_pattern_frame();
        int start_cnt;
        start_cnt = frame_cnt;
        fork
            begin
                for (int k = 0; k < his_pkg::HITS_PER_FRAME; k++) begin
                    send_hit(his_pkg::BIN_W'((hit_idx / his_pkg::HITS_PER_PIXEL)
                                             % his_pkg::NUM_PIXELS));
                end
                idle_cycles(1);
            end
            collect_dump(0);
        join
        check_value("frame_done count", start_cnt + 1, frame_cnt);
        check_value("fill_bank", 1, int'(fill_bank));
    endtask

    task automatic random_bin_runs();
        int start_cnt;
        start_cnt = frame_cnt;
        fork
            begin
                send_random_frame();
                idle_cycles(1);
            end
            collect_dump(1);
        join
        check_value("frame_done count", start_cnt + 1, frame_cnt);
        check_value("fill_bank", 0, int'(fill_bank));
    endtask

    // third frame reuses bank 0 after its clear-on-read
    task automatic back_to_back_frames();
        int start_cnt;
        start_cnt = frame_cnt;
        fork
            begin
                repeat (3) send_random_frame();
                idle_cycles(1);
            end
            begin
                collect_dump(0);
                collect_dump(1);
                collect_dump(0);
            end
        join
        check_value("frame_done count", start_cnt + 3, frame_cnt);
        check_value("fill_bank", 1, int'(fill_bank));
    endtask

    task automatic gapped_hit_frame();
        int start_cnt;
        start_cnt = frame_cnt;
        fork
            begin
                for (int k = 0; k < his_pkg::HITS_PER_FRAME; k++) begin
                    send_hit(his_pkg::BIN_W'(take_bits(his_pkg::BIN_W)));
                    if (k == his_pkg::HITS_PER_FRAME - 1) begin
                        // 35 hits taken, last one not yet sampled
                        @(negedge clk);
                        check_value("frame_done before last hit", 0, int'(frame_done));
                        check_value("frame_done count before last hit", start_cnt, frame_cnt);
                    end
                    idle_cycles(take_bits(2));
                end
                idle_cycles(1);
            end
            collect_dump(1);
        join
        check_value("frame_done count", start_cnt + 1, frame_cnt);
    endtask

    task automatic reset_mid_frame();
        int start_cnt;
        for (int k = 0; k < 20; k++) begin
            send_hit(his_pkg::BIN_W'(take_bits(his_pkg::BIN_W)));
        end
        idle_cycles(1);
        apply_reset();
        // partial frame is gone in the DUT, so drop it from the model too
        clear_model();
        @(negedge clk);
        check_value("fill_bank after reset", 0, int'(fill_bank));
        start_cnt = frame_cnt;
        fork
            begin
                send_random_frame();
                idle_cycles(1);
            end
            collect_dump(0);
        join
        check_value("frame_done count", start_cnt + 1, frame_cnt);
    endtask

    initial begin
        clk = 1'b0;
        res = 1'b0;
        hit_valid = 1'b0;
        hit_bin = '0;
        lfsr = 16'd23659;
        checks = 0;
        errors = 0;
        clear_model();
        repeat (3) @(posedge clk);
        res <= 1'b1;

        idle_after_reset();
        fixed_pattern_frame();
        random_bin_runs();
        back_to_back_frames();
        // partial hits land in bank 1, the gapped frame refills it later
        reset_mid_frame();
        gapped_hit_frame();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- source/his_builder_top.sv
module his_builder_top (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       hit_valid,
    input  logic [his_pkg::BIN_W-1:0]   hit_bin,
    output logic                       frame_done,
    output logic                       fill_bank,
    output logic                       out_valid,
    output logic                       out_bank,
    output logic [his_pkg::PIX_W-1:0]   out_pixel,
    output logic [his_pkg::BIN_W-1:0]   out_bin,
    output logic [his_pkg::COUNT_W-1:0] out_count
);

    // hit path
    logic                       upd_valid;
    logic                       upd_bank;
    logic [his_pkg::PIX_W-1:0]   upd_pixel;
    logic [his_pkg::BIN_W-1:0]   upd_bin;

    // readout path
    logic                       rd_en;
    logic                       rd_bank;
    logic [his_pkg::PIX_W-1:0]   rd_pixel;
    logic [his_pkg::BIN_W-1:0]   rd_bin;
    logic [his_pkg::COUNT_W-1:0] rd_count;

    hit_sequencer hit_sequencer_inst (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .upd_valid  (upd_valid),
        .upd_bank   (upd_bank),
        .upd_pixel  (upd_pixel),
        .upd_bin    (upd_bin),
        .frame_done (frame_done),
        .fill_bank  (fill_bank)
    );

    bin_accumulator bin_accumulator_inst (
        .clk       (clk),
        .res       (res),
        .upd_valid (upd_valid),
        .upd_bank  (upd_bank),
        .upd_pixel (upd_pixel),
        .upd_bin   (upd_bin),
        .rd_en     (rd_en),
        .rd_bank   (rd_bank),
        .rd_pixel  (rd_pixel),
        .rd_bin    (rd_bin),
        .rd_count  (rd_count)
    );

    hist_readout hist_readout_inst (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .fill_bank  (fill_bank),
        .rd_en      (rd_en),
        .rd_bank    (rd_bank),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count),
        .out_valid  (out_valid),
        .out_bank   (out_bank),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count)
    );

endmodule

//--- source/hist_readout.sv
module hist_readout (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       frame_done,
    input  logic                       fill_bank,
    // read and clear port to the accumulator
    output logic                       rd_en,
    output logic                       rd_bank,
    output logic [his_pkg::PIX_W-1:0]   rd_pixel,
    output logic [his_pkg::BIN_W-1:0]   rd_bin,
    input  logic [his_pkg::COUNT_W-1:0] rd_count,
    // word stream
    output logic                       out_valid,
    output logic                       out_bank,
    output logic [his_pkg::PIX_W-1:0]   out_pixel,
    output logic [his_pkg::BIN_W-1:0]   out_bin,
    output logic [his_pkg::COUNT_W-1:0] out_count
);

    his_pkg::readout_state_t state;
    logic [his_pkg::DRAIN_W-1:0] drain_cnt;

    logic last_bin;
    logic last_pix;

    assign last_bin = (rd_bin == his_pkg::LAST_BIN);
    assign last_pix = (rd_pixel == his_pkg::LAST_PIXEL);

    // one read per streaming cycle
    assign rd_en = (state == his_pkg::RO_STREAM);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= his_pkg::RO_IDLE;
            drain_cnt <= '0;
            rd_bank <= 1'b0;
            rd_pixel <= '0;
            rd_bin <= '0;
        end else begin
            case (state)
                his_pkg::RO_IDLE: begin
                    if (frame_done) begin
                        // fill_bank already swapped, finished bank is the other one
                        rd_bank <= ~fill_bank;
                        drain_cnt <= '0;
                        rd_pixel <= '0;
                        rd_bin <= '0;
                        state <= his_pkg::RO_DRAIN;
                    end
                end
                his_pkg::RO_DRAIN: begin
                    // let the last updates land
                    if (drain_cnt == his_pkg::LAST_DRAIN) begin
                        state <= his_pkg::RO_STREAM;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                his_pkg::RO_STREAM: begin
                    // pixel major, bins ascending
                    if (!last_bin) begin
                        rd_bin <= rd_bin + 1'b1;
                    end else begin
                        rd_bin <= '0;
                        if (last_pix) begin
                            state <= his_pkg::RO_DONE;
                        end else begin
                            rd_pixel <= rd_pixel + 1'b1;
                        end
                    end
                end
                his_pkg::RO_DONE: begin
                    // re-arm
                    rd_pixel <= '0;
                    state <= his_pkg::RO_IDLE;
                end
                default: begin
                    state <= his_pkg::RO_IDLE;
                end
            endcase
        end
    end

    // align the word tag with rd_count
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        out_bank <= rd_bank;
        out_pixel <= rd_pixel;
        out_bin <= rd_bin;
    end

    assign out_count = rd_count;

    // frames are longer than a readout, so a new one only arrives in idle
    a_no_overrun: assert property (@(posedge clk) disable iff (!res)
        frame_done |-> state == his_pkg::RO_IDLE);

endmodule

//--- source/bin_accumulator.sv
module bin_accumulator (
    input  logic                       clk,
    input  logic                       res,
    // update port from the sequencer
    input  logic                       upd_valid,
    input  logic                       upd_bank,
    input  logic [his_pkg::PIX_W-1:0]   upd_pixel,
    input  logic [his_pkg::BIN_W-1:0]   upd_bin,
    // read and clear port from readout
    input  logic                       rd_en,
    input  logic                       rd_bank,
    input  logic [his_pkg::PIX_W-1:0]   rd_pixel,
    input  logic [his_pkg::BIN_W-1:0]   rd_bin,
    output logic [his_pkg::COUNT_W-1:0] rd_count
);

    // two banks of per-pixel histograms in flops
    logic [his_pkg::COUNT_W-1:0] mem [2][his_pkg::NUM_PIXELS][his_pkg::NUM_BINS];

    // read stage
    logic                       s1_valid;
    logic                       s1_bank;
    logic [his_pkg::PIX_W-1:0]   s1_pixel;
    logic [his_pkg::BIN_W-1:0]   s1_bin;
    logic [his_pkg::COUNT_W-1:0] s1_count;

    // write stage value
    logic [his_pkg::COUNT_W-1:0] wr_count;
    // incoming update hits the entry still being written
    logic                       fwd;

    assign wr_count = s1_count + 1'b1;

    assign fwd = s1_valid
              && (s1_bank == upd_bank)
              && (s1_pixel == upd_pixel)
              && (s1_bin == upd_bin);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= upd_valid;
        end
    end

    // capture address and old count
    always_ff @(posedge clk) begin
        if (upd_valid) begin
            s1_bank <= upd_bank;
            s1_pixel <= upd_pixel;
            s1_bin <= upd_bin;
            // storage is one write behind on a repeat address
            if (fwd) begin
                s1_count <= wr_count;
            end else begin
                s1_count <= mem[upd_bank][upd_pixel][upd_bin];
            end
        end
    end

    // counter store
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // whole store cleared on reset
            for (int b = 0; b < 2; b++) begin
                for (int p = 0; p < his_pkg::NUM_PIXELS; p++) begin
                    for (int n = 0; n < his_pkg::NUM_BINS; n++) begin
                        mem[b][p][n] <= '0;
                    end
                end
            end
        end else begin
            // write stage of the update pipe
            if (s1_valid) begin
                mem[s1_bank][s1_pixel][s1_bin] <= wr_count;
            end
            // clear on read, always the idle bank
            if (rd_en) begin
                mem[rd_bank][rd_pixel][rd_bin] <= '0;
            end
        end
    end

    // read port, count valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_count <= mem[rd_bank][rd_pixel][rd_bin];
        end
    end

    // readout never touches a bank with updates in flight
    a_bank_split: assert property (@(posedge clk) disable iff (!res)
        rd_en |-> !(upd_valid && (upd_bank == rd_bank))
               && !(s1_valid && (s1_bank == rd_bank)));

endmodule

//--- source/hit_sequencer.sv
module hit_sequencer (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     hit_valid,
    input  logic [his_pkg::BIN_W-1:0] hit_bin,
    output logic                     upd_valid,
    output logic                     upd_bank,
    output logic [his_pkg::PIX_W-1:0] upd_pixel,
    output logic [his_pkg::BIN_W-1:0] upd_bin,
    output logic                     frame_done,
    output logic                     fill_bank
);

    // counter chain
    logic [his_pkg::HIT_W-1:0]   hit_cnt;
    logic [his_pkg::PIX_W-1:0]   pix_cnt;
    logic [his_pkg::ACQ_W-1:0]   acq_cnt;

    logic last_hit;
    logic last_pix;
    logic last_acq;
    logic frame_end;

    assign last_hit = (hit_cnt == his_pkg::LAST_HIT);
    assign last_pix = (pix_cnt == his_pkg::LAST_PIXEL);
    assign last_acq = (acq_cnt == his_pkg::LAST_ACQ);
    // last hit of last pixel of last acquisition
    assign frame_end = hit_valid && last_hit && last_pix && last_acq;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_cnt <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (hit_valid) begin
            if (!last_hit) begin
                hit_cnt <= hit_cnt + 1'b1;
            end else begin
                // pixel done, move on
                hit_cnt <= '0;
                if (!last_pix) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end else begin
                    // acquisition done
                    pix_cnt <= '0;
                    acq_cnt <= last_acq ? '0 : acq_cnt + 1'b1;
                end
            end
        end
    end

    // strobes and bank select
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            upd_valid <= 1'b0;
            frame_done <= 1'b0;
            fill_bank <= 1'b0;
        end else begin
            upd_valid <= hit_valid;
            frame_done <= frame_end;
            // swap banks together with frame_done
            if (frame_end) begin
                fill_bank <= ~fill_bank;
            end
        end
    end

    // update payload, tagged with the bank before the swap
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            upd_bank <= fill_bank;
            upd_pixel <= pix_cnt;
            upd_bin <= hit_bin;
        end
    end

    // pixel index of an update in range
    a_pixel_range: assert property (@(posedge clk) disable iff (!res)
        upd_valid |-> upd_pixel <= his_pkg::LAST_PIXEL);

endmodule

//--- source/his_pkg.sv
package his_pkg;

    // histogram geometry
    localparam int NUM_BINS = 8;
    localparam int BIN_W = 3;
    localparam int NUM_PIXELS = 4;
    localparam int PIX_W = 2;

    // hit ordering
    // hits for one pixel before moving on
    localparam int HITS_PER_PIXEL = 3;
    localparam int HIT_W = 2;
    localparam int NUM_ACQ = 3;
    localparam int ACQ_W = 2;

    // max count per bin is HITS_PER_PIXEL * NUM_ACQ = 9
    localparam int COUNT_W = 4;

    localparam int HITS_PER_FRAME = HITS_PER_PIXEL * NUM_PIXELS * NUM_ACQ;
    localparam int FRAME_W = $clog2(HITS_PER_FRAME);

    // accumulator depth waited out before reading the finished bank
    localparam int DRAIN_CYCLES = 2;
    localparam int DRAIN_W = $clog2(DRAIN_CYCLES);

    // terminal values at counter width
    localparam logic [HIT_W-1:0] LAST_HIT = HIT_W'(HITS_PER_PIXEL - 1);
    localparam logic [PIX_W-1:0] LAST_PIXEL = PIX_W'(NUM_PIXELS - 1);
    localparam logic [ACQ_W-1:0] LAST_ACQ = ACQ_W'(NUM_ACQ - 1);
    localparam logic [BIN_W-1:0] LAST_BIN = BIN_W'(NUM_BINS - 1);
    localparam logic [FRAME_W-1:0] LAST_FRAME_HIT = FRAME_W'(HITS_PER_FRAME - 1);
    localparam logic [DRAIN_W-1:0] LAST_DRAIN = DRAIN_W'(DRAIN_CYCLES - 1);

    // readout fsm
    typedef enum logic [1:0] {
        RO_IDLE,
        RO_DRAIN,
        RO_STREAM,
        RO_DONE
    } readout_state_t;

endpackage
